//--- verilog/cpuPkg.sv
package cpuPkg;

  localparam int dataWidth = 32;
  localparam int regIndexWidth = 5;

  // Memory depths in words
  localparam int imemWords = 256;
  localparam int dmemWords = 256;

  // Peripheral byte addresses
  localparam logic [dataWidth-1:0] ioOutAddr = 32'h0000_1000;
  localparam logic [dataWidth-1:0] ioButtonAddr = 32'h0000_1004;

  typedef enum logic [6:0] {
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opOpImm  = 7'b0010011,
    opOp     = 7'b0110011,
    opBranch = 7'b1100011,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111
  } opcodeE;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSll,
    aluSrl,
    aluSra,
    aluSlt,
    aluSltu,
    aluPassB
  } aluOpE;

endpackage

//--- verilog/Control.sv
`timescale 1ns/1ps

module Control (
  input  logic [cpuPkg::dataWidth-1:0] instr,
  output cpuPkg::aluOpE                aluOp,
  output logic                         aluSrcImm,
  output logic                         aluSrcPc,
  output logic                         memRead,
  output logic                         memWrite,
  output logic                         regWrite,
  output logic                         isBranch,
  output logic                         isJal,
  output logic                         isJalr,
  output logic [cpuPkg::dataWidth-1:0] imm
);

  cpuPkg::opcodeE opcode;
  logic [2:0] funct3;
  logic       altFunct;
  cpuPkg::aluOpE arithOp;

  assign opcode = cpuPkg::opcodeE'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign altFunct = instr[30];

  // Shared by OP and OP-IMM, SUB only exists in the register form
  always_comb begin
    case (funct3)
      3'b000: arithOp = (opcode == cpuPkg::opOp && altFunct) ? cpuPkg::aluSub : cpuPkg::aluAdd;
      3'b001: arithOp = cpuPkg::aluSll;
      3'b010: arithOp = cpuPkg::aluSlt;
      3'b011: arithOp = cpuPkg::aluSltu;
      3'b100: arithOp = cpuPkg::aluXor;
      3'b101: arithOp = altFunct ? cpuPkg::aluSra : cpuPkg::aluSrl;
      3'b110: arithOp = cpuPkg::aluOr;
      default: arithOp = cpuPkg::aluAnd;
    endcase
  end

  always_comb begin
    aluOp = cpuPkg::aluAdd;
    aluSrcImm = 1'b0;
    aluSrcPc = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    regWrite = 1'b0;
    isBranch = 1'b0;
    isJal = 1'b0;
    isJalr = 1'b0;
    imm = {{20{instr[31]}}, instr[31:20]};
    case (opcode)
      cpuPkg::opOp: begin
        aluOp = arithOp;
        regWrite = 1'b1;
      end
      cpuPkg::opOpImm: begin
        aluOp = arithOp;
        aluSrcImm = 1'b1;
        regWrite = 1'b1;
      end
      cpuPkg::opLoad: begin
        aluSrcImm = 1'b1;
        memRead = 1'b1;
        regWrite = 1'b1;
      end
      cpuPkg::opStore: begin
        aluSrcImm = 1'b1;
        memWrite = 1'b1;
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      cpuPkg::opBranch: begin
        isBranch = 1'b1;
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      cpuPkg::opJal: begin
        isJal = 1'b1;
        regWrite = 1'b1;
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      cpuPkg::opJalr: begin
        isJalr = 1'b1;
        regWrite = 1'b1;
      end
      cpuPkg::opLui: begin
        aluOp = cpuPkg::aluPassB;
        aluSrcImm = 1'b1;
        regWrite = 1'b1;
        imm = {instr[31:12], 12'b0};
      end
      cpuPkg::opAuipc: begin
        aluSrcImm = 1'b1;
        aluSrcPc = 1'b1;
        regWrite = 1'b1;
        imm = {instr[31:12], 12'b0};
      end
      default: begin
        // Unknown opcode leaves every write disabled
        imm = '0;
      end
    endcase
  end

endmodule

//--- verilog/RegisterFile.sv
`timescale 1ns/1ps

module RegisterFile (
  input  logic                             clk,
  input  logic                             arstN,
  input  logic [cpuPkg::regIndexWidth-1:0] rs1,
  input  logic [cpuPkg::regIndexWidth-1:0] rs2,
  input  logic                             wbWe,
  input  logic [cpuPkg::regIndexWidth-1:0] wbIndex,
  input  logic [cpuPkg::dataWidth-1:0]     wbData,
  output logic [cpuPkg::dataWidth-1:0]     rs1Data,
  output logic [cpuPkg::dataWidth-1:0]     rs2Data
);

  logic [cpuPkg::dataWidth-1:0] regs [32];
  logic wbLive;

  // x0 never takes a write, neither in storage nor through the bypass
  assign wbLive = wbWe && wbIndex != '0;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wbLive) begin
      regs[wbIndex] <= wbData;
    end
  end

  // Writeback in the same cycle wins over the stored value
  assign rs1Data = (wbLive && wbIndex == rs1) ? wbData : regs[rs1];
  assign rs2Data = (wbLive && wbIndex == rs2) ? wbData : regs[rs2];

  x0StaysZero: assert property (@(posedge clk) disable iff (!arstN)
    (rs1 != '0 || rs1Data == '0) && (rs2 != '0 || rs2Data == '0))
    else $error("x0 read back nonzero");

endmodule

//--- verilog/Alu.sv
`timescale 1ns/1ps

module Alu (
  input  cpuPkg::aluOpE                op,
  input  logic [cpuPkg::dataWidth-1:0] a,
  input  logic [cpuPkg::dataWidth-1:0] b,
  input  logic [2:0]                   funct3,
  output logic [cpuPkg::dataWidth-1:0] result,
  output logic                         branchTaken
);

  logic [4:0] shamt;
  logic       lessSigned;
  logic       lessUnsigned;

  assign shamt = b[4:0];
  assign lessSigned = $signed(a) < $signed(b);
  assign lessUnsigned = a < b;

  always_comb begin
    case (op)
      cpuPkg::aluAdd:   result = a + b;
      cpuPkg::aluSub:   result = a - b;
      cpuPkg::aluAnd:   result = a & b;
      cpuPkg::aluOr:    result = a | b;
      cpuPkg::aluXor:   result = a ^ b;
      cpuPkg::aluSll:   result = a << shamt;
      cpuPkg::aluSrl:   result = a >> shamt;
      cpuPkg::aluSra:   result = $signed(a) >>> shamt;
      cpuPkg::aluSlt:   result = {{(cpuPkg::dataWidth-1){1'b0}}, lessSigned};
      cpuPkg::aluSltu:  result = {{(cpuPkg::dataWidth-1){1'b0}}, lessUnsigned};
      cpuPkg::aluPassB: result = b;
      default:          result = '0;
    endcase
  end

  // Branch condition from funct3
  always_comb begin
    case (funct3)
      3'b000:  branchTaken = a == b;
      3'b001:  branchTaken = a != b;
      3'b100:  branchTaken = lessSigned;
      3'b101:  branchTaken = !lessSigned;
      3'b110:  branchTaken = lessUnsigned;
      3'b111:  branchTaken = !lessUnsigned;
      default: branchTaken = 1'b0;
    endcase
  end

endmodule

//--- verilog/HazardUnit.sv
`timescale 1ns/1ps

module HazardUnit (
  input  logic [cpuPkg::regIndexWidth-1:0] idRs1,
  input  logic [cpuPkg::regIndexWidth-1:0] idRs2,
  input  logic [cpuPkg::regIndexWidth-1:0] exRs1,
  input  logic [cpuPkg::regIndexWidth-1:0] exRs2,
  input  logic [cpuPkg::regIndexWidth-1:0] exRd,
  input  logic                             exMemRead,
  input  logic [cpuPkg::regIndexWidth-1:0] memRd,
  input  logic                             memRegWrite,
  input  logic [cpuPkg::regIndexWidth-1:0] wbRd,
  input  logic                             wbRegWrite,
  output logic [1:0]                       fwdASel,
  output logic [1:0]                       fwdBSel,
  output logic                             stall
);

  // 0 register value, 1 memory stage, 2 writeback
  function automatic logic [1:0] pickSource(input logic [cpuPkg::regIndexWidth-1:0] rs);
    logic [1:0] sel;
    sel = 2'd0;
    if (rs != '0) begin
      if (memRegWrite && memRd == rs) begin
        sel = 2'd1;
      end else if (wbRegWrite && wbRd == rs) begin
        sel = 2'd2;
      end
    end
    return sel;
  endfunction

  assign fwdASel = pickSource(exRs1);
  assign fwdBSel = pickSource(exRs2);

  // Load result is not ready for the next instruction
  assign stall = exMemRead && exRd != '0 && (exRd == idRs1 || exRd == idRs2);

endmodule

//--- verilog/Mmu.sv
`timescale 1ns/1ps

module Mmu (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic [cpuPkg::dataWidth-1:0] instrAddr,
  input  logic [cpuPkg::dataWidth-1:0] dataAddr,
  input  logic [cpuPkg::dataWidth-1:0] dataWdata,
  input  logic                         dataWe,
  input  logic                         dataRe,
  input  logic                         button,
  output logic [cpuPkg::dataWidth-1:0] instrData,
  output logic [cpuPkg::dataWidth-1:0] dataRdata,
  output logic                         ioStrobe,
  output logic [cpuPkg::dataWidth-1:0] ioData
);

  logic [cpuPkg::dataWidth-1:0] rom [cpuPkg::imemWords];
  logic [cpuPkg::dataWidth-1:0] ram [cpuPkg::dmemWords];
  logic [$clog2(cpuPkg::imemWords)-1:0] romIndex;
  logic [$clog2(cpuPkg::dmemWords)-1:0] ramIndex;
  logic isOut;
  logic isButton;

  initial $readmemh("verif/program.hex", rom);

  // Word index wraps within the array depth
  assign romIndex = instrAddr[$clog2(cpuPkg::imemWords)+1:2];
  assign ramIndex = dataAddr[$clog2(cpuPkg::dmemWords)+1:2];
  assign instrData = rom[romIndex];

  assign isOut = dataAddr == cpuPkg::ioOutAddr;
  assign isButton = dataAddr == cpuPkg::ioButtonAddr;

  always_comb begin
    dataRdata = '0;
    if (dataRe) begin
      if (isButton) begin
        dataRdata = {{(cpuPkg::dataWidth-1){1'b0}}, button};
      end else if (!isOut) begin
        dataRdata = ram[ramIndex];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dataWe && !isOut && !isButton) begin
      ram[ramIndex] <= dataWdata;
    end
    if (dataWe && isOut) begin
      ioData <= dataWdata;
    end
  end

  // One pulse per store to the output port
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ioStrobe <= 1'b0;
    end else begin
      ioStrobe <= dataWe && isOut;
    end
  end

  pcAligned: assert property (@(posedge clk) disable iff (!arstN) instrAddr[1:0] == 2'b00)
    else $error("misaligned fetch address %h", instrAddr);

endmodule

//--- verilog/Cpu.sv
`timescale 1ns/1ps

module Cpu (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic                         button,
  output logic                         ioStrobe,
  output logic [cpuPkg::dataWidth-1:0] ioData
);

  // Fetch
  logic [cpuPkg::dataWidth-1:0] pc, instrData;

  // Decode
  logic idValid;
  logic [cpuPkg::dataWidth-1:0] idInstr, idPc, rs1Data, rs2Data, idImm;
  logic [cpuPkg::regIndexWidth-1:0] idRs1, idRs2, idRd;
  cpuPkg::aluOpE idAluOp;
  logic idAluSrcImm, idAluSrcPc, idMemRead, idMemWrite, idRegWrite;
  logic idIsBranch, idIsJal, idIsJalr, stall;

  // Execute
  cpuPkg::aluOpE exAluOp;
  logic exAluSrcImm, exAluSrcPc, exMemRead, exMemWrite, exRegWrite;
  logic exIsBranch, exIsJal, exIsJalr, branchTaken, redirect;
  logic [cpuPkg::dataWidth-1:0] exPc, exRs1Data, exRs2Data, exImm;
  logic [cpuPkg::dataWidth-1:0] fwdA, fwdB, aluA, aluB, aluResult, exResult;
  logic [cpuPkg::dataWidth-1:0] jalrSum, target;
  logic [cpuPkg::regIndexWidth-1:0] exRs1, exRs2, exRd;
  logic [2:0] exFunct3;
  logic [1:0] fwdASel, fwdBSel;

  // Memory and writeback
  logic memMemRead, memMemWrite, memRegWrite, wbMemRead, wbRegWrite;
  logic [cpuPkg::dataWidth-1:0] memResult, memWdata, dataRdata;
  logic [cpuPkg::dataWidth-1:0] wbResult, wbMemData, wbData;
  logic [cpuPkg::regIndexWidth-1:0] memRd, wbRd;

  assign idRs1 = idInstr[19:15];
  assign idRs2 = idInstr[24:20];
  assign idRd = idInstr[11:7];

  Control control (
    .instr(idInstr), .aluOp(idAluOp), .aluSrcImm(idAluSrcImm), .aluSrcPc(idAluSrcPc),
    .memRead(idMemRead), .memWrite(idMemWrite), .regWrite(idRegWrite),
    .isBranch(idIsBranch), .isJal(idIsJal), .isJalr(idIsJalr), .imm(idImm)
  );

  RegisterFile registerFile (
    .clk(clk), .arstN(arstN), .rs1(idRs1), .rs2(idRs2), .wbWe(wbRegWrite),
    .wbIndex(wbRd), .wbData(wbData), .rs1Data(rs1Data), .rs2Data(rs2Data)
  );

  HazardUnit hazardUnit (
    .idRs1(idRs1), .idRs2(idRs2), .exRs1(exRs1), .exRs2(exRs2), .exRd(exRd),
    .exMemRead(exMemRead), .memRd(memRd), .memRegWrite(memRegWrite), .wbRd(wbRd),
    .wbRegWrite(wbRegWrite), .fwdASel(fwdASel), .fwdBSel(fwdBSel), .stall(stall)
  );

  Alu alu (
    .op(exAluOp), .a(aluA), .b(aluB), .funct3(exFunct3),
    .result(aluResult), .branchTaken(branchTaken)
  );

  Mmu mmu (
    .clk(clk), .arstN(arstN), .instrAddr(pc), .dataAddr(memResult), .dataWdata(memWdata),
    .dataWe(memMemWrite), .dataRe(memMemRead), .button(button), .instrData(instrData),
    .dataRdata(dataRdata), .ioStrobe(ioStrobe), .ioData(ioData)
  );

  // Operand forwarding, memory stage is the younger producer
  always_comb begin
    case (fwdASel)
      2'd1:    fwdA = memResult;
      2'd2:    fwdA = wbData;
      default: fwdA = exRs1Data;
    endcase
    case (fwdBSel)
      2'd1:    fwdB = memResult;
      2'd2:    fwdB = wbData;
      default: fwdB = exRs2Data;
    endcase
  end

  assign aluA = exAluSrcPc ? exPc : fwdA;
  assign aluB = exAluSrcImm ? exImm : fwdB;

  assign jalrSum = fwdA + exImm;
  assign target = exIsJalr ? {jalrSum[cpuPkg::dataWidth-1:1], 1'b0} : exPc + exImm;
  assign redirect = (exIsBranch && branchTaken) || exIsJal || exIsJalr;
  // Jumps link to the next instruction
  assign exResult = (exIsJal || exIsJalr) ? exPc + 32'd4 : aluResult;

  assign wbData = wbMemRead ? wbMemData : wbResult;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= '0;
      idValid <= 1'b0;
    end else if (redirect) begin
      pc <= target;
      idValid <= 1'b0;
    end else if (!stall) begin
      pc <= pc + 32'd4;
      idValid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!redirect && !stall) begin
      idInstr <= instrData;
      idPc <= pc;
    end
  end

  // Flush or load-use bubble clears the execute controls
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {exAluSrcImm, exAluSrcPc, exMemRead, exMemWrite, exRegWrite} <= '0;
      {exIsBranch, exIsJal, exIsJalr} <= '0;
      exAluOp <= cpuPkg::aluAdd;
    end else if (redirect || stall || !idValid) begin
      {exAluSrcImm, exAluSrcPc, exMemRead, exMemWrite, exRegWrite} <= '0;
      {exIsBranch, exIsJal, exIsJalr} <= '0;
      exAluOp <= cpuPkg::aluAdd;
    end else begin
      {exAluSrcImm, exAluSrcPc} <= {idAluSrcImm, idAluSrcPc};
      {exMemRead, exMemWrite, exRegWrite} <= {idMemRead, idMemWrite, idRegWrite};
      {exIsBranch, exIsJal, exIsJalr} <= {idIsBranch, idIsJal, idIsJalr};
      exAluOp <= idAluOp;
    end
  end

  always_ff @(posedge clk) begin
    exPc <= idPc;
    exRs1Data <= rs1Data;
    exRs2Data <= rs2Data;
    exImm <= idImm;
    exRs1 <= idRs1;
    exRs2 <= idRs2;
    exRd <= idRd;
    exFunct3 <= idInstr[14:12];
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {memMemRead, memMemWrite, memRegWrite} <= '0;
      {wbMemRead, wbRegWrite} <= '0;
    end else begin
      {memMemRead, memMemWrite, memRegWrite} <= {exMemRead, exMemWrite, exRegWrite};
      {wbMemRead, wbRegWrite} <= {memMemRead, memRegWrite};
    end
  end

  always_ff @(posedge clk) begin
    memResult <= exResult;
    memWdata <= fwdB;
    memRd <= exRd;
    wbResult <= memResult;
    wbMemData <= dataRdata;
    wbRd <= memRd;
  end

  // A load in execute never redirects, so a stalled fetch/decode register is never flushed
  noStallOnRedirect: assert property (@(posedge clk) disable iff (!arstN) !(stall && redirect))
    else $error("load-use stall coincided with a redirect");

endmodule

//--- verif/CpuTb.sv
`timescale 1ns/1ps

module CpuTb;

  localparam int numEntries = 12;
  // Generous budget per output word, plus reset and startup
  localparam int cycleLimit = 40 * numEntries + 50;
  localparam logic [31:0] lfsrSeed = 32'h8117fd31;

  logic clk;
  logic arstN;
  logic button;
  logic ioStrobe;
  logic [cpuPkg::dataWidth-1:0] ioData;

  logic [31:0] expectWord [numEntries];
  logic buttonEntry [numEntries];
  logic [31:0] lfsr;
  int errors;
  int checks;
  int cycles;

  Cpu uut (
    .clk(clk),
    .arstN(arstN),
    .button(button),
    .ioStrobe(ioStrobe),
    .ioData(ioData)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // Button entries take one LFSR bit as the level and expect it back in bit 0
  task automatic setEntry(input int idx, input logic [31:0] word, input logic isButton);
    if (isButton) begin
      lfsr = lfsrNext(lfsr);
      expectWord[idx] = {31'b0, lfsr[0]};
    end else begin
      expectWord[idx] = word;
    end
    buttonEntry[idx] = isButton;
  endtask

  task automatic fillTable();
    // xor of shifted difference with 100
    setEntry(0, 32'hFFFF_FE30, 1'b0);
    // andi, or, slt and sltu folded together
    setEntry(1, 32'h0000_0661, 1'b0);
    // Load-use sum
    setEntry(2, 32'h0000_0662, 1'b0);
    // Fall-through after the not-taken bne
    setEntry(3, 32'h0000_0055, 1'b0);
    // Link of the jal at 0x68
    setEntry(4, 32'h0000_006C, 1'b0);
    setEntry(5, 32'h0000_003A, 1'b0);
    setEntry(6, 32'h0, 1'b1);
    setEntry(7, 32'h0, 1'b1);
    setEntry(8, 32'h0, 1'b1);
    setEntry(9, 32'h0, 1'b1);
    setEntry(10, 32'hABCD_E000, 1'b0);
    // Loop branch offset is -2072, three passes leave the auipc at PC 0xFFFFE8A8
    setEntry(11, 32'h1234_38A8, 1'b0);
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL at %0t: %s = %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // Strobe lasts one cycle, so each pulse is seen at exactly one falling edge
  task automatic waitStrobe();
    do begin
      @(negedge clk);
    end while (!ioStrobe);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    lfsr = lfsrSeed;
    button = 1'b0;
    arstN = 1'b0;
    fillTable();
    repeat (8) @(posedge clk);
    arstN <= 1'b1;
    for (int i = 0; i < numEntries; i++) begin
      if (buttonEntry[i]) begin
        @(posedge clk);
        button <= expectWord[i][0];
      end
      waitStrobe();
      checkValue("ioData", ioData, expectWord[i]);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < cycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the output strobe never came within %0d cycles", cycleLimit);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- verilog.f
verilog/cpuPkg.sv
verilog/Control.sv
verilog/RegisterFile.sv
verilog/Alu.sv
verilog/HazardUnit.sv
verilog/Mmu.sv
verilog/Cpu.sv
verif/CpuTb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module CpuTb -f verilog.f -Mdir obj_dir
	@out="$$(./obj_dir/VCpuTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

//--- verif/program.hex
// One RV32I instruction word per line, loaded from address 0
// Arithmetic, logic, shifts and compares
00001537
06400093
FF900113
40110233
00421293
4022D313
001343B3
00752023
01C2D413
001124B3
0020B5B3
7F037613
00866633
00960633
00B60633
00C52023
// Store then dependent load
00C02823
01002683
00968733
00E52023
// Taken beq skips two stores, bne falls through
00B48663
00152023
00252023
00B49463
05500793
00F52023
// Call and return
00C000EF
01052023
0100006F
00152023
03A00813
00008067
// Button loop with a delay before each read
00400893
00600913
FFF90913
FE091EE3
00452983
01352023
FFF88893
FE089463
// Upper immediates, then spin
ABCDEA37
01452023
12345A97
01552023
0000006F
